//--- hdl/glue_pkg.sv
// ------------------------------
// Shared constants for the MiSTer configuration glue
// Status-word bit map, field widths and crop numbers
// Import into module bodies, or use scoped names in port lists
// ------------------------------
`default_nettype none

package glue_pkg;

    // OSD status word
    localparam int STATUS_W       = 64;

    // Crop switch and vertical crop option
    localparam int CROP_EN_BIT    = 41;
    localparam int VCOPT_LSB      = 42;
    localparam int VCOPT_W        = 4;

    // Integer scaling field, 2 bits in the status word
    localparam int CROP_SCALE_LSB = 46;
    localparam int SCALE_FLD_W    = 2;

    // CRT horizontal scaling enable
    localparam int HSIZE_EN_BIT   = 48;

    // Scanline effect field
    localparam int SCANFX_LSB     = 3;
    localparam int SCANFX_W       = 3;

    // HDMI mode reported by the framework
    localparam int HDMI_DIM_W     = 12;
    localparam int FULL_HD_W      = 1920;
    localparam int FULL_HD_H      = 1080;

    // Crop outputs
    localparam int CROP_LINES     = 216;
    localparam int CROP_SIZE_W    = 12;
    localparam int CROP_OFF_W     = 5;
    localparam int SCALE_W        = 3;

    // Options from 6 upwards give a negative offset
    localparam int VCOPT_WRAP     = 6;
    localparam int VCOPT_BIAS     = 24;

    // PS/2 mouse packet, bit 24 toggles per packet
    localparam int MOUSE_PKT_W    = 25;
    localparam int MOUSE_DELTA_W  = 9;
    localparam int MOUSE_FLAGS_W  = 8;

    // OSD menu mask, a set bit hides the item
    localparam int MENUMASK_W     = 16;

    // Debug bus and debug byte
    localparam int DBG_W          = 8;

endpackage

`default_nettype wire

//--- hdl/glue_ifs.sv
// ------------------------------
// Buses between the glue blocks
// crop_if carries the crop settings, mouse_if the decoded mouse
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

interface crop_if;
    import glue_pkg::*;

    logic                          crop_ok;
    logic                          crop_en;
    // -16 to +15 lines
    logic signed [CROP_OFF_W-1:0]  crop_off;
    logic [CROP_SIZE_W-1:0]        crop_size;
    logic [SCALE_W-1:0]            crop_scale;

    modport ctrl (output crop_ok, crop_en, crop_off, crop_size, crop_scale);
    modport mon  (input  crop_ok, crop_en, crop_off, crop_size, crop_scale);
endinterface

interface mouse_if;
    import glue_pkg::*;

    logic signed [MOUSE_DELTA_W-1:0] dx;
    logic signed [MOUSE_DELTA_W-1:0] dy;
    logic [MOUSE_FLAGS_W-1:0]        flags;
    // One-cycle new packet strobe
    logic                            st;

    modport dec (output dx, dy, flags, st);
    modport mon (input  dx, dy, flags, st);
endinterface

`default_nettype wire

//--- hdl/osd_crop_ctrl.sv
// ------------------------------
// Vertical crop settings from the OSD status and HDMI mode
// Cropping only works on a plain 1080p output
// Size settles two cycles after the inputs, the rest after one
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module osd_crop_ctrl (
    input  wire                            clk_sys,
    input  wire                            arst_n,
    input  wire [glue_pkg::STATUS_W-1:0]   status,
    input  wire [glue_pkg::HDMI_DIM_W-1:0] hdmi_width,
    input  wire [glue_pkg::HDMI_DIM_W-1:0] hdmi_height,
    input  wire                            direct_video,
    input  wire                            force_scan2x,
    input  wire                            rotate_en,
    crop_if.ctrl                           crop
);
    import glue_pkg::*;

    logic [VCOPT_W-1:0]     vcopt;
    logic [SCALE_FLD_W-1:0] scale_fld;
    logic [SCANFX_W-1:0]    scanfx;
    logic [CROP_OFF_W-1:0]  vcopt_x2;
    logic                   full_hd;
    logic                   crop_allowed;

    // Status fields
    assign vcopt     = status[VCOPT_LSB +: VCOPT_W];
    assign scale_fld = status[CROP_SCALE_LSB +: SCALE_FLD_W];
    assign scanfx    = status[SCANFX_LSB +: SCANFX_W];

    assign vcopt_x2  = {vcopt, 1'b0};

    assign full_hd = (hdmi_width == HDMI_DIM_W'(FULL_HD_W)) &&
                     (hdmi_height == HDMI_DIM_W'(FULL_HD_H));

    // Any video setting that rescales the picture rules cropping out
    assign crop_allowed = full_hd && (scanfx == '0) && (scale_fld == '0) &&
                          !direct_video && !force_scan2x && !rotate_en;

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            crop.crop_ok   <= 1'b0;
            crop.crop_en   <= 1'b0;
            crop.crop_size <= '0;
        end else begin
            crop.crop_ok   <= crop_allowed;
            crop.crop_en   <= status[CROP_EN_BIT];
            // Built from last cycle's permission and switch
            crop.crop_size <= (crop.crop_ok && crop.crop_en) ?
                              CROP_SIZE_W'(CROP_LINES) : '0;
        end
    end

    // Offset wraps to negative from option 6 upwards
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            crop.crop_off   <= '0;
            crop.crop_scale <= '0;
        end else begin
            if (vcopt < VCOPT_W'(VCOPT_WRAP)) begin
                crop.crop_off <= vcopt_x2;
            end else begin
                crop.crop_off <= vcopt_x2 - CROP_OFF_W'(VCOPT_BIAS);
            end
            crop.crop_scale <= SCALE_W'(scale_fld);
        end
    end

    // The scaler only understands no crop or a 216-line window
    a_crop_size_legal : assert property (
        @(posedge clk_sys) disable iff (!arst_n)
        (crop.crop_size == '0) || (crop.crop_size == CROP_SIZE_W'(CROP_LINES))
    ) else $error("crop_size outside {0, CROP_LINES}");

endmodule

`default_nettype wire

//--- hdl/mouse_decode.sv
// ------------------------------
// PS/2 mouse packet decoder
// A change of packet bit 24 marks a new packet and fires st
// Deltas and flags are captured in the strobe cycle
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module mouse_decode (
    input  wire                             clk_sys,
    input  wire                             arst_n,
    input  wire [glue_pkg::MOUSE_PKT_W-1:0] ps2_mouse,
    mouse_if.dec                            mouse
);
    import glue_pkg::*;

    logic toggle_l;
    logic new_pkt;

    assign new_pkt = ps2_mouse[MOUSE_PKT_W-1] ^ toggle_l;

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            toggle_l <= 1'b0;
            mouse.st <= 1'b0;
        end else begin
            toggle_l <= ps2_mouse[MOUSE_PKT_W-1];
            mouse.st <= new_pkt;
        end
    end

    // Sign bits of the deltas live in the flags byte
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            mouse.flags <= '0;
            mouse.dx    <= '0;
            mouse.dy    <= '0;
        end else if (new_pkt) begin
            mouse.flags <= ps2_mouse[7:0];
            mouse.dx    <= {ps2_mouse[4], ps2_mouse[15:8]};
            mouse.dy    <= {ps2_mouse[5], ps2_mouse[23:16]};
        end
    end

    // Strobe needs a real toggle one cycle earlier
    a_st_needs_toggle : assert property (
        @(posedge clk_sys) disable iff (!arst_n)
        mouse.st |-> $past(ps2_mouse[MOUSE_PKT_W-1] != toggle_l)
    ) else $error("mouse st without a toggle of packet bit 24");

endmodule

`default_nettype wire

//--- hdl/cfg_monitor.sv
// ------------------------------
// OSD menu mask and debug byte
// Counts mouse packets and picks a debug byte with debug_bus
// Both outputs are registered, one cycle after their inputs
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module cfg_monitor (
    input  wire                             clk_sys,
    input  wire                             arst_n,
    input  wire [glue_pkg::STATUS_W-1:0]    status,
    input  wire                             direct_video,
    input  wire                             vertical,
    input  wire [glue_pkg::DBG_W-1:0]       debug_bus,
    crop_if.mon                             crop,
    mouse_if.mon                            mouse,
    output logic [glue_pkg::MENUMASK_W-1:0] status_menumask,
    output logic [glue_pkg::DBG_W-1:0]      target_info
);
    import glue_pkg::*;

    logic [STATUS_W/DBG_W-1:0][DBG_W-1:0] status_bytes;
    logic [MENUMASK_W-1:0]                menumask_nxt;
    logic [DBG_W-1:0]                     dbg_nxt;
    logic [DBG_W-1:0]                     pkt_cnt;

    assign status_bytes = status;

    // Rotate options and Scan FX options stay hidden in this build
    assign menumask_nxt = {
        {(MENUMASK_W-6){1'b0}},
        crop.crop_ok,
        1'b1,
        1'b1,
        ~status[HSIZE_EN_BIT],
        ~vertical,
        direct_video
    };

    always_comb begin
        dbg_nxt = '0;
        case (debug_bus[7:6])
            2'd0: dbg_nxt = status_bytes[debug_bus[2:0]];
            2'd1: begin
                case (debug_bus[3:0])
                    4'd0: dbg_nxt = mouse.dx[DBG_W-1:0];
                    4'd1: dbg_nxt = mouse.dy[DBG_W-1:0];
                    4'd2: dbg_nxt = mouse.flags;
                    4'd3: dbg_nxt = {6'd0, mouse.dy[MOUSE_DELTA_W-1],
                                     mouse.dx[MOUSE_DELTA_W-1]};
                    4'd4: dbg_nxt = pkt_cnt;
                    4'd5: dbg_nxt = crop.crop_size[DBG_W-1:0];
                    4'd6: dbg_nxt = {crop.crop_scale, crop.crop_off};
                    4'd7: dbg_nxt = {6'd0, crop.crop_en, crop.crop_ok};
                    default: dbg_nxt = '0;
                endcase
            end
            default: dbg_nxt = '0;
        endcase
    end

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            pkt_cnt         <= '0;
            status_menumask <= '0;
            target_info     <= '0;
        end else begin
            // Wraps after 255 packets
            if (mouse.st) begin
                pkt_cnt <= pkt_cnt + 1'b1;
            end
            status_menumask <= menumask_nxt;
            target_info     <= dbg_nxt;
        end
    end

    // Fixed-hidden items latch on the first clock out of reset
    a_mask_fixed_ones : assert property (
        @(posedge clk_sys) disable iff (!arst_n)
        1'b1 |=> (status_menumask[4:3] == 2'b11)
    ) else $error("menu mask bits 4:3 not set after reset");

endmodule

`default_nettype wire

//--- hdl/mister_glue_top.sv
// ------------------------------
// MiSTer configuration glue, top level
// Crop control and mouse decoder feed the OSD and debug monitor
// All logic runs on clk_sys
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module mister_glue_top (
    input  wire                                clk_sys,
    input  wire                                arst_n,
    input  wire [glue_pkg::STATUS_W-1:0]       status,
    input  wire [glue_pkg::HDMI_DIM_W-1:0]     hdmi_width,
    input  wire [glue_pkg::HDMI_DIM_W-1:0]     hdmi_height,
    input  wire                                direct_video,
    input  wire                                force_scan2x,
    input  wire [1:0]                          rotate,
    input  wire [6:0]                          core_mod,
    input  wire [glue_pkg::MOUSE_PKT_W-1:0]    ps2_mouse,
    input  wire [glue_pkg::DBG_W-1:0]          debug_bus,
    output wire [glue_pkg::CROP_SIZE_W-1:0]    crop_size,
    output wire [glue_pkg::CROP_OFF_W-1:0]     crop_off,
    output wire [glue_pkg::SCALE_W-1:0]        crop_scale,
    output wire [glue_pkg::MOUSE_DELTA_W-1:0]  mouse_dx,
    output wire [glue_pkg::MOUSE_DELTA_W-1:0]  mouse_dy,
    output wire [glue_pkg::MOUSE_FLAGS_W-1:0]  mouse_flags,
    output wire                                mouse_st,
    output wire [glue_pkg::MENUMASK_W-1:0]     status_menumask,
    output wire [glue_pkg::DBG_W-1:0]          target_info
);

    crop_if  crop_bus ();
    mouse_if mouse_bus ();

    osd_crop_ctrl u_crop (
        .clk_sys      ( clk_sys       ),
        .arst_n       ( arst_n        ),
        .status       ( status        ),
        .hdmi_width   ( hdmi_width    ),
        .hdmi_height  ( hdmi_height   ),
        .direct_video ( direct_video  ),
        .force_scan2x ( force_scan2x  ),
        // Only the rotate enable matters, not the direction
        .rotate_en    ( rotate[0]     ),
        .crop         ( crop_bus.ctrl )
    );

    mouse_decode u_mouse (
        .clk_sys   ( clk_sys        ),
        .arst_n    ( arst_n         ),
        .ps2_mouse ( ps2_mouse      ),
        .mouse     ( mouse_bus.dec  )
    );

    // core_mod bit 0 flags a vertical game
    cfg_monitor u_mon (
        .clk_sys         ( clk_sys         ),
        .arst_n          ( arst_n          ),
        .status          ( status          ),
        .direct_video    ( direct_video    ),
        .vertical        ( core_mod[0]     ),
        .debug_bus       ( debug_bus       ),
        .crop            ( crop_bus.mon    ),
        .mouse           ( mouse_bus.mon   ),
        .status_menumask ( status_menumask ),
        .target_info     ( target_info     )
    );

    assign crop_size   = crop_bus.crop_size;
    assign crop_off    = crop_bus.crop_off;
    assign crop_scale  = crop_bus.crop_scale;

    assign mouse_dx    = mouse_bus.dx;
    assign mouse_dy    = mouse_bus.dy;
    assign mouse_flags = mouse_bus.flags;
    assign mouse_st    = mouse_bus.st;

endmodule

`default_nettype wire

//--- sim/tb_mister_glue.sv
// ------------------------------
// Directed testbench for mister_glue_top
// Runs crop, mouse, menu mask and debug byte tests in turn
// Stops at the first mismatch, a watchdog bounds the run
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_mister_glue;
    import glue_pkg::*;

    localparam int SETTLE_CYCLES = 4;
    localparam int MOUSE_PKTS    = 20;
    localparam int MASK_ROUNDS   = 24;
    // Rough cycle budget per test, each applied case costs about 5 cycles
    localparam int TEST_CYCLES   = 20 + 50 + 80 + MOUSE_PKTS * 4 + MASK_ROUNDS * 5 + 310;
    localparam int TIMEOUT_NS    = TEST_CYCLES * 8 * 2;

    logic                    clk_sys = 1'b0;
    logic                    arst_n;
    logic [STATUS_W-1:0]     status;
    logic [HDMI_DIM_W-1:0]   hdmi_width;
    logic [HDMI_DIM_W-1:0]   hdmi_height;
    logic                    direct_video;
    logic                    force_scan2x;
    logic [1:0]              rotate;
    logic [6:0]              core_mod;
    logic [MOUSE_PKT_W-1:0]  ps2_mouse;
    logic [DBG_W-1:0]        debug_bus;
    wire [CROP_SIZE_W-1:0]   crop_size;
    wire [CROP_OFF_W-1:0]    crop_off;
    wire [SCALE_W-1:0]       crop_scale;
    wire [MOUSE_DELTA_W-1:0] mouse_dx;
    wire [MOUSE_DELTA_W-1:0] mouse_dy;
    wire [MOUSE_FLAGS_W-1:0] mouse_flags;
    wire                     mouse_st;
    wire [MENUMASK_W-1:0]    status_menumask;
    wire [DBG_W-1:0]         target_info;

    integer                  seed = 32'h3229_0ebd;
    logic [MOUSE_PKT_W-1:0]  last_pkt;
    int                      pkt_sent;

    mister_glue_top u_mister_glue_top (
        .clk_sys         ( clk_sys         ),
        .arst_n          ( arst_n          ),
        .status          ( status          ),
        .hdmi_width      ( hdmi_width      ),
        .hdmi_height     ( hdmi_height     ),
        .direct_video    ( direct_video    ),
        .force_scan2x    ( force_scan2x    ),
        .rotate          ( rotate          ),
        .core_mod        ( core_mod        ),
        .ps2_mouse       ( ps2_mouse       ),
        .debug_bus       ( debug_bus       ),
        .crop_size       ( crop_size       ),
        .crop_off        ( crop_off        ),
        .crop_scale      ( crop_scale      ),
        .mouse_dx        ( mouse_dx        ),
        .mouse_dy        ( mouse_dy        ),
        .mouse_flags     ( mouse_flags     ),
        .mouse_st        ( mouse_st        ),
        .status_menumask ( status_menumask ),
        .target_info     ( target_info     )
    );

    always #4 clk_sys = ~clk_sys;

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: actual 0x%0h, expected 0x%0h", name, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Outputs are sampled on the falling edge, well clear of the drive edge
    task automatic settle();
        repeat (SETTLE_CYCLES) @(posedge clk_sys);
        @(negedge clk_sys);
    endtask

    function automatic logic [STATUS_W-1:0] make_status(input logic en, input logic [3:0] vcopt,
                                                        input logic [1:0] scale,
                                                        input logic [2:0] scanfx);
        logic [STATUS_W-1:0] s;
        s = '0;
        s[CROP_EN_BIT] = en;
        s[VCOPT_LSB +: 4] = vcopt;
        s[CROP_SCALE_LSB +: 2] = scale;
        s[SCANFX_LSB +: 3] = scanfx;
        return s;
    endfunction

    // Twice the option, minus the bias from the wrap point on, kept to 5 bits
    function automatic logic [4:0] offset_expect(input int v);
        int raw;
        raw = (v < VCOPT_WRAP) ? 2 * v : 2 * v - VCOPT_BIAS;
        return raw[4:0];
    endfunction

    task automatic apply_crop_case(input logic [STATUS_W-1:0] st, input int w, input int h,
                                   input logic dv, input logic s2x, input logic [1:0] rot,
                                   input logic exp_ok);
        @(posedge clk_sys);
        status       <= st;
        hdmi_width   <= w[HDMI_DIM_W-1:0];
        hdmi_height  <= h[HDMI_DIM_W-1:0];
        direct_video <= dv;
        force_scan2x <= s2x;
        rotate       <= rot;
        settle();
        check_value("crop_size", crop_size, (exp_ok && st[CROP_EN_BIT]) ? CROP_LINES : 0);
        check_value("status_menumask[5]", status_menumask[5], exp_ok);
    endtask

    task automatic send_packet(input logic [23:0] body);
        logic [MOUSE_PKT_W-1:0] pkt;
        pkt = {~ps2_mouse[24], body};
        @(posedge clk_sys);
        ps2_mouse <= pkt;
        @(negedge clk_sys);
        check_value("mouse_st", mouse_st, 1'b0);
        @(negedge clk_sys);
        check_value("mouse_st", mouse_st, 1'b1);
        check_value("mouse_dx", mouse_dx, {pkt[4], pkt[15:8]});
        check_value("mouse_dy", mouse_dy, {pkt[5], pkt[23:16]});
        check_value("mouse_flags", mouse_flags, pkt[7:0]);
        @(negedge clk_sys);
        check_value("mouse_st", mouse_st, 1'b0);
        last_pkt = pkt;
        pkt_sent++;
    endtask

    task automatic check_reset();
        repeat (15) @(posedge clk_sys);
        @(negedge clk_sys);
        check_value("crop_size", crop_size, 0);
        check_value("status_menumask", status_menumask, 0);
        check_value("target_info", target_info, 0);
        check_value("mouse_st", mouse_st, 0);
        @(posedge clk_sys);
        arst_n <= 1'b1;
        @(posedge clk_sys);
        @(negedge clk_sys);
        check_value("status_menumask[4:3]", status_menumask[4:3], 2'b11);
    endtask

    task automatic run_crop_blockers();
        apply_crop_case(make_status(1, 0, 0, 0), 1920, 1080, 0, 0, 2'b00, 1);
        apply_crop_case(make_status(0, 0, 0, 0), 1920, 1080, 0, 0, 2'b00, 1);
        apply_crop_case(make_status(1, 0, 0, 2), 1920, 1080, 0, 0, 2'b00, 0);
        apply_crop_case(make_status(1, 0, 1, 0), 1920, 1080, 0, 0, 2'b00, 0);
        apply_crop_case(make_status(1, 0, 0, 0), 1920, 1080, 1, 0, 2'b00, 0);
        apply_crop_case(make_status(1, 0, 0, 0), 1920, 1080, 0, 1, 2'b00, 0);
        apply_crop_case(make_status(1, 0, 0, 0), 1920, 1080, 0, 0, 2'b01, 0);
        // Rotate direction alone is no blocker
        apply_crop_case(make_status(1, 0, 0, 0), 1920, 1080, 0, 0, 2'b10, 1);
        apply_crop_case(make_status(1, 0, 0, 0), 1280, 720, 0, 0, 2'b00, 0);
    endtask

    task automatic sweep_crop_offsets();
        for (int v = 0; v < 16; v++) begin
            @(posedge clk_sys);
            status <= make_status(0, v[3:0], v[1:0], 0);
            settle();
            check_value("crop_off", crop_off, offset_expect(v));
            check_value("crop_scale", crop_scale, {1'b0, v[1:0]});
        end
    endtask

    task automatic send_mouse_packets();
        for (int i = 0; i < MOUSE_PKTS; i++) begin
            send_packet($random(seed));
        end
    endtask

    task automatic randomize_menu_inputs();
        logic [STATUS_W-1:0]   st;
        logic [31:0]           r;
        logic                  ok;
        logic [MENUMASK_W-1:0] exp_mask;
        for (int i = 0; i < MASK_ROUNDS; i++) begin
            st = {$random(seed), $random(seed)};
            r = $random(seed);
            // Every other round clears the blocking fields so crop_ok can rise
            if (i % 2 == 0) begin
                st[SCANFX_LSB +: 3] = '0;
                st[CROP_SCALE_LSB +: 2] = '0;
            end
            ok = (st[SCANFX_LSB +: 3] == 0) && (st[CROP_SCALE_LSB +: 2] == 0) && !r[0];
            exp_mask = {10'd0, ok, 2'b11, ~st[HSIZE_EN_BIT], ~r[1], r[0]};
            @(posedge clk_sys);
            status       <= st;
            direct_video <= r[0];
            core_mod     <= r[7:1];
            hdmi_width   <= HDMI_DIM_W'(1920);
            hdmi_height  <= HDMI_DIM_W'(1080);
            force_scan2x <= 1'b0;
            rotate       <= 2'b00;
            settle();
            check_value("status_menumask", status_menumask, exp_mask);
        end
    endtask

    task automatic check_group1(input logic [11:0] sz, input logic [4:0] off,
                                input logic [2:0] scale, input logic en, input logic ok);
        logic [7:0] exp_byte;
        for (int idx = 0; idx < 16; idx++) begin
            @(posedge clk_sys);
            debug_bus <= {4'b0100, idx[3:0]};
            settle();
            case (idx)
                0:       exp_byte = last_pkt[15:8];
                1:       exp_byte = last_pkt[23:16];
                2:       exp_byte = last_pkt[7:0];
                3:       exp_byte = {6'd0, last_pkt[5], last_pkt[4]};
                4:       exp_byte = pkt_sent[7:0];
                5:       exp_byte = sz[7:0];
                6:       exp_byte = {scale, off};
                7:       exp_byte = {6'd0, en, ok};
                default: exp_byte = 8'd0;
            endcase
            check_value($sformatf("target_info grp1 idx %0d", idx), target_info, exp_byte);
        end
    endtask

    task automatic read_debug_bytes();
        logic [STATUS_W-1:0] st;
        logic [31:0]         r;
        repeat (3) send_packet($random(seed));
        @(posedge clk_sys);
        status <= make_status(1, 9, 0, 0);
        direct_video <= 1'b0;
        settle();
        check_group1(CROP_LINES, offset_expect(9), 3'd0, 1'b1, 1'b1);
        @(posedge clk_sys);
        status <= make_status(1, 9, 3, 0);
        settle();
        check_group1(12'd0, offset_expect(9), 3'd3, 1'b1, 1'b0);
        for (int i = 0; i < 16; i++) begin
            st = {$random(seed), $random(seed)};
            r = $random(seed);
            @(posedge clk_sys);
            status    <= st;
            debug_bus <= {2'b00, r[5:0]};
            settle();
            check_value("target_info grp0", target_info, st[r[2:0] * 8 +: 8]);
        end
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            @(posedge clk_sys);
            debug_bus <= {1'b1, r[6:0]};
            settle();
            check_value("target_info grp2/3", target_info, 0);
        end
    endtask

    initial begin
        arst_n       = 1'b0;
        status       = '0;
        hdmi_width   = '0;
        hdmi_height  = '0;
        direct_video = 1'b0;
        force_scan2x = 1'b0;
        rotate       = '0;
        core_mod     = '0;
        ps2_mouse    = '0;
        debug_bus    = '0;
        last_pkt     = '0;
        pkt_sent     = 0;
        check_reset();
        run_crop_blockers();
        sweep_crop_offsets();
        send_mouse_packets();
        randomize_menu_inputs();
        read_debug_bytes();
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: tests did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

//--- verilog.f
hdl/glue_pkg.sv
hdl/glue_ifs.sv
hdl/osd_crop_ctrl.sv
hdl/mouse_decode.sv
hdl/cfg_monitor.sv
hdl/mister_glue_top.sv
sim/tb_mister_glue.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, verdict taken from the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_mister_glue -o tb_mister_glue
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_mister_glue > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
exit 0
